// File: logic/operand_pkg.sv
package operand_pkg;

  // Instruction window after prefix stripping, with the opcode in byte 0
  localparam int instr_bits = 88;

  // Data and address words are always 32 bits in this front end
  typedef logic [31:0] word_t;

  // General register numbering, as encoded in the opcode, ModR/M and SIB
  typedef enum logic [2:0] {
    eax = 3'd0,
    ecx = 3'd1,
    edx = 3'd2,
    ebx = 3'd3,
    esp = 3'd4,
    ebp = 3'd5,
    esi = 3'd6,
    edi = 3'd7
  } reg_idx_e;

  // The whole register file flattened, indexed by reg_idx_e
  typedef word_t [7:0] reg_file_t;

  // How the two operands are encoded in the instruction
  typedef enum logic [3:0] {
    form_none    = 4'd0,
    form_reg     = 4'd1,
    form_imm     = 4'd2,
    form_eax_imm = 4'd3,
    form_reg_imm = 4'd4,
    form_eax_reg = 4'd5,
    form_rm      = 4'd6,
    form_rm_reg  = 4'd7,
    form_reg_rm  = 4'd8,
    form_rm_imm  = 4'd9
  } opnd_form_e;

  // Coarse opcode class; the decode only cares whether it is LEA
  typedef enum logic [1:0] {
    cmd_alu = 2'd0,
    cmd_mov = 2'd1,
    cmd_lea = 2'd2
  } opc_e;

  // Where an operand's result goes back to
  typedef enum logic [1:0] {
    dest_none = 2'd0,
    dest_reg  = 2'd1,
    dest_mem  = 2'd2
  } dest_kind_e;

  // Bytes after the opcode, at most ten
  typedef logic [3:0] body_len_t;

endpackage

// File: logic/modrm_decoder.sv
`timescale 1ns/1ps

module modrm_decoder import operand_pkg::*; (
  input  logic [instr_bits-1:0] instr,
  input  opnd_form_e            opnd_form,
  input  logic                  imm_1byte,
  output logic [7:0]            modrm,
  output logic [7:0]            sib,
  output logic                  has_sib,
  output word_t                 disp,
  output word_t                 imm,
  output logic                  rm_is_direct,
  output body_len_t             instr_body_len
);

  logic                  has_modrm;
  logic                  has_imm;
  logic                  is_disp8;
  logic                  is_disp32;
  logic [1:0]            mod_field;
  logic [2:0]            rm_field;
  logic [3:0]            disp_len;
  logic [3:0]            imm_len;
  logic [3:0]            disp_start;
  logic [3:0]            imm_start;
  logic [instr_bits-1:0] disp_window;
  logic [instr_bits-1:0] imm_window;

  // Only the rm forms carry a ModR/M byte
  assign has_modrm = opnd_form inside {form_rm, form_rm_reg, form_reg_rm, form_rm_imm};
  assign has_imm   = opnd_form inside {form_imm, form_eax_imm, form_reg_imm, form_rm_imm};

  // ModR/M always sits right behind the opcode, SIB right behind ModR/M
  assign modrm     = instr[15:8];
  assign sib       = instr[23:16];
  assign mod_field = modrm[7:6];
  assign rm_field  = modrm[2:0];

  // mod 11 selects a register instead of memory
  assign rm_is_direct = has_modrm && (mod_field == 2'b11);

  // rm 100 in a memory mode escapes to a SIB byte
  assign has_sib = has_modrm && (mod_field != 2'b11) && (rm_field == 3'b100);

  assign is_disp8 = has_modrm && (mod_field == 2'b01);

  // mod 00 with rm 101, or with SIB base 101, swaps the base for a disp32
  assign is_disp32 = has_modrm &&
                     ((mod_field == 2'b10) ||
                      ((mod_field == 2'b00) && (rm_field == 3'b101)) ||
                      ((mod_field == 2'b00) && has_sib && (sib[2:0] == 3'b101)));

  assign disp_len = is_disp32 ? 4'd4 : (is_disp8 ? 4'd1 : 4'd0);
  assign imm_len  = !has_imm ? 4'd0 : (imm_1byte ? 4'd1 : 4'd4);

  // Byte offsets from the opcode; the displacement only exists with ModR/M
  assign disp_start = 4'd2 + {3'b000, has_sib};
  assign imm_start  = 4'd1 + {3'b000, has_modrm} + {3'b000, has_sib} + disp_len;

  // Slide the wanted field down to bit 0
  assign disp_window = instr >> {disp_start, 3'b000};
  assign imm_window  = instr >> {imm_start, 3'b000};

  // Both short forms are sign-extended to a full word
  assign disp = is_disp32 ? disp_window[31:0] :
                is_disp8  ? {{24{disp_window[7]}}, disp_window[7:0]} :
                            '0;

  assign imm = (imm_len == 4'd4) ? imm_window[31:0] :
               (imm_len == 4'd1) ? {{24{imm_window[7]}}, imm_window[7:0]} :
                                   '0;

  // The opcode byte itself is not counted
  assign instr_body_len = {3'b000, has_modrm} + {3'b000, has_sib} + disp_len + imm_len;

endmodule

// File: logic/memory_operand.sv
`timescale 1ns/1ps

module memory_operand import operand_pkg::*; (
  input  reg_file_t  gpr,
  input  logic [7:0] modrm,
  input  logic [7:0] sib,
  input  logic       has_sib,
  input  word_t      disp,
  input  opc_e       opc,
  input  logic       hint1_is_write,
  input  word_t      hint1_address,
  input  word_t      hint1_data,
  input  logic       hint2_is_write,
  input  word_t      hint2_address,
  input  word_t      hint2_data,
  output word_t      mem_addr,
  output word_t      mem_value
);

  reg_idx_e   base_sel;
  reg_idx_e   index_sel;
  logic [1:0] scale;
  logic       no_base;
  logic       no_index;
  word_t      base_val;
  word_t      index_val;
  logic       hint1_hit;
  logic       hint2_hit;

  // With SIB the base comes from SIB.base, otherwise from ModR/M.rm
  assign base_sel  = reg_idx_e'(has_sib ? sib[2:0] : modrm[2:0]);
  assign index_sel = reg_idx_e'(sib[5:3]);
  assign scale     = sib[7:6];

  // An index encoding of ESP means no index at all
  assign no_index = !has_sib || (index_sel == esp);

  // In mod 00 an EBP base encoding is replaced by the disp32
  assign no_base = (modrm[7:6] == 2'b00) && (base_sel == ebp);

  assign base_val  = no_base ? '0 : gpr[base_sel];
  assign index_val = no_index ? '0 : gpr[index_sel];

  // Wraps modulo 2^32 like the real address adder
  assign mem_addr = base_val + (index_val << scale) + disp;

  // A hint only counts when it is a read of exactly this address
  assign hint1_hit = !hint1_is_write && (hint1_address == mem_addr);
  assign hint2_hit = !hint2_is_write && (hint2_address == mem_addr);

  // LEA never touches memory and returns the address itself
  assign mem_value = (opc == cmd_lea) ? mem_addr   :
                     hint1_hit        ? hint1_data :
                     hint2_hit        ? hint2_data :
                                        '0;

endmodule

// File: logic/operand_router.sv
`timescale 1ns/1ps

module operand_router import operand_pkg::*; (
  input  logic [instr_bits-1:0] instr,
  input  opnd_form_e            opnd_form,
  input  logic [7:0]            modrm,
  input  logic                  rm_is_direct,
  input  word_t                 imm,
  input  reg_file_t             gpr,
  input  word_t                 mem_addr,
  input  word_t                 mem_value,
  input  logic                  opnd0_is_read,
  input  logic                  opnd0_is_write,
  input  logic                  opnd1_is_read,
  input  logic                  opnd1_is_write,
  input  logic                  opnd1_is_one,
  output word_t                 opnd0_r,
  output word_t                 opnd1_r,
  output dest_kind_e            dest0_kind,
  output dest_kind_e            dest1_kind,
  output word_t                 dest0_sel,
  output word_t                 dest1_sel
);

  reg_idx_e opc_reg;
  reg_idx_e reg_field;
  reg_idx_e rm_reg;
  reg_idx_e opnd0_idx;
  reg_idx_e opnd1_idx;
  logic     opnd0_reg_src;
  logic     opnd0_rm;
  logic     opnd0_imm;
  logic     opnd1_reg_src;
  logic     opnd1_rm;
  logic     opnd1_imm;
  logic     opnd0_is_reg;
  logic     opnd0_is_mem;
  logic     opnd1_is_reg;
  logic     opnd1_is_mem;

  // Read value priority: implicit one, register, memory, immediate
  function automatic word_t pick_read(input logic  is_one,
                                      input logic  is_read,
                                      input logic  is_reg,
                                      input logic  is_mem,
                                      input logic  is_imm,
                                      input word_t reg_val,
                                      input word_t mem_val,
                                      input word_t imm_val);
    if (is_one)
      return 32'd1;
    if (is_read && is_reg)
      return reg_val;
    if (is_read && is_mem)
      return mem_val;
    if (is_imm)
      return imm_val;
    return '0;
  endfunction

  // An operand that is not written back has no destination
  function automatic dest_kind_e pick_kind(input logic is_write,
                                           input logic is_reg,
                                           input logic is_mem);
    if (is_write && is_reg)
      return dest_reg;
    if (is_write && is_mem)
      return dest_mem;
    return dest_none;
  endfunction

  // The three places a register number can come from
  assign opc_reg   = reg_idx_e'(instr[2:0]);
  assign reg_field = reg_idx_e'(modrm[5:3]);
  assign rm_reg    = reg_idx_e'(modrm[2:0]);

  // Operand 0 source classes; implicit EAX counts as a plain register
  assign opnd0_reg_src = opnd_form inside {form_reg, form_reg_imm, form_eax_imm,
                                           form_eax_reg, form_reg_rm};
  assign opnd0_rm      = opnd_form inside {form_rm, form_rm_reg, form_rm_imm};
  assign opnd0_imm     = (opnd_form == form_imm);

  assign opnd0_idx = (opnd_form inside {form_reg, form_reg_imm}) ? opc_reg   :
                     (opnd_form == form_reg_rm)                  ? reg_field :
                     opnd0_rm                                    ? rm_reg    :
                                                                   eax;

  // Operand 1 never uses implicit EAX
  assign opnd1_reg_src = opnd_form inside {form_eax_reg, form_rm_reg};
  assign opnd1_rm      = (opnd_form == form_reg_rm);
  assign opnd1_imm     = opnd_form inside {form_eax_imm, form_reg_imm, form_rm_imm};

  assign opnd1_idx = (opnd_form == form_eax_reg) ? opc_reg   :
                     (opnd_form == form_rm_reg)  ? reg_field :
                     opnd1_rm                    ? rm_reg    :
                                                   eax;

  // ModR/M.rm is a register only in direct mode, memory otherwise
  assign opnd0_is_reg = opnd0_reg_src || (opnd0_rm && rm_is_direct);
  assign opnd0_is_mem = opnd0_rm && !rm_is_direct;
  assign opnd1_is_reg = opnd1_reg_src || (opnd1_rm && rm_is_direct);
  assign opnd1_is_mem = opnd1_rm && !rm_is_direct;

  assign opnd0_r = pick_read(1'b0, opnd0_is_read, opnd0_is_reg, opnd0_is_mem, opnd0_imm,
                             gpr[opnd0_idx], mem_value, imm);
  assign opnd1_r = pick_read(opnd1_is_one, opnd1_is_read, opnd1_is_reg, opnd1_is_mem,
                             opnd1_imm, gpr[opnd1_idx], mem_value, imm);

  assign dest0_kind = pick_kind(opnd0_is_write, opnd0_is_reg, opnd0_is_mem);
  assign dest1_kind = pick_kind(opnd1_is_write, opnd1_is_reg, opnd1_is_mem);

  // Register writes are selected one-hot, memory writes by address
  assign dest0_sel = (dest0_kind == dest_reg) ? (32'd1 << opnd0_idx) :
                     (dest0_kind == dest_mem) ? mem_addr             :
                                                '0;
  assign dest1_sel = (dest1_kind == dest_reg) ? (32'd1 << opnd1_idx) :
                     (dest1_kind == dest_mem) ? mem_addr             :
                                                '0;

endmodule

// File: logic/decode_handshake.sv
`timescale 1ns/1ps

module decode_handshake import operand_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  word_t      dec_opnd0_r,
  input  word_t      dec_opnd1_r,
  input  dest_kind_e dec_dest0_kind,
  input  dest_kind_e dec_dest1_kind,
  input  word_t      dec_dest0_sel,
  input  word_t      dec_dest1_sel,
  input  body_len_t  dec_instr_body_len,
  output logic       ack,
  output word_t      opnd0_r,
  output word_t      opnd1_r,
  output dest_kind_e dest0_kind,
  output dest_kind_e dest1_kind,
  output word_t      dest0_sel,
  output word_t      dest1_sel,
  output body_len_t  instr_body_len
);

  // done means a result is held and ack is up
  typedef enum logic {
    idle,
    done
  } state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= idle;
      opnd0_r        <= '0;
      opnd1_r        <= '0;
      dest0_kind     <= dest_none;
      dest1_kind     <= dest_none;
      dest0_sel      <= '0;
      dest1_sel      <= '0;
      instr_body_len <= '0;
    end else begin
      case (state)
        idle: begin
          // Results are sampled once, on the edge that sees the new request
          if (req) begin
            state          <= done;
            opnd0_r        <= dec_opnd0_r;
            opnd1_r        <= dec_opnd1_r;
            dest0_kind     <= dec_dest0_kind;
            dest1_kind     <= dec_dest1_kind;
            dest0_sel      <= dec_dest0_sel;
            dest1_sel      <= dec_dest1_sel;
            instr_body_len <= dec_instr_body_len;
          end
        end
        done: begin
          // Hold everything until the requester lets go of req
          if (!req)
            state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  assign ack = (state == done);

endmodule

// File: logic/decode_opnds.sv
`timescale 1ns/1ps

module decode_opnds import operand_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic [instr_bits-1:0] instr,
  input  reg_file_t             gpr,
  input  opc_e                  opc,
  input  opnd_form_e            opnd_form,
  input  logic                  imm_1byte,
  input  logic                  opnd0_is_read,
  input  logic                  opnd0_is_write,
  input  logic                  opnd1_is_read,
  input  logic                  opnd1_is_write,
  input  logic                  opnd1_is_one,
  input  logic                  hint1_is_write,
  input  word_t                 hint1_address,
  input  word_t                 hint1_data,
  input  logic                  hint2_is_write,
  input  word_t                 hint2_address,
  input  word_t                 hint2_data,
  output logic                  ack,
  output word_t                 opnd0_r,
  output word_t                 opnd1_r,
  output dest_kind_e            dest0_kind,
  output dest_kind_e            dest1_kind,
  output word_t                 dest0_sel,
  output word_t                 dest1_sel,
  output body_len_t             instr_body_len
);

  // Fields pulled out of the instruction bytes
  logic [7:0] modrm;
  logic [7:0] sib;
  logic       has_sib;
  word_t      disp;
  word_t      imm;
  logic       rm_is_direct;

  // Single address unit shared by whichever operand is in memory
  word_t mem_addr;
  word_t mem_value;

  // Combinational results waiting for the handshake to capture them
  word_t      dec_opnd0_r;
  word_t      dec_opnd1_r;
  dest_kind_e dec_dest0_kind;
  dest_kind_e dec_dest1_kind;
  word_t      dec_dest0_sel;
  word_t      dec_dest1_sel;
  body_len_t  dec_instr_body_len;

  modrm_decoder modrm_decoder_inst (
    .*,
    .instr_body_len (dec_instr_body_len)
  );

  memory_operand memory_operand_inst (.*);

  // Router outputs feed the capture registers, not the ports
  operand_router operand_router_inst (
    .*,
    .opnd0_r    (dec_opnd0_r),
    .opnd1_r    (dec_opnd1_r),
    .dest0_kind (dec_dest0_kind),
    .dest1_kind (dec_dest1_kind),
    .dest0_sel  (dec_dest0_sel),
    .dest1_sel  (dec_dest1_sel)
  );

  decode_handshake decode_handshake_inst (.*);

endmodule

// File: sim/decode_ref.svh
`ifndef decode_ref_svh
`define decode_ref_svh

// Source classes an operand can resolve to
localparam int src_none = 0;
localparam int src_reg  = 1;
localparam int src_rm   = 2;
localparam int src_mem  = 3;
localparam int src_imm  = 4;

// Byte n of the instruction, byte 0 is the opcode
function automatic logic [7:0] byte_at(input int n);
  return instr[8*n +: 8];
endfunction

// Little-endian field of one or four bytes, a single byte is sign-extended
function automatic word_t field_at(input int start, input int nbytes);
  word_t v;
  v = '0;
  for (int i = 0; i < nbytes; i++) begin
    v[8*i +: 8] = byte_at(start + i);
  end
  if (nbytes == 1)
    v = {{24{v[7]}}, v[7:0]};
  return v;
endfunction

// Register, then memory, then immediate, else zero
function automatic word_t read_value(input int src, input int idx, input logic is_read,
                                     input word_t mem_v, input word_t imm_v);
  if (is_read && src == src_reg)
    return gpr[idx];
  if (is_read && src == src_mem)
    return mem_v;
  if (src == src_imm)
    return imm_v;
  return '0;
endfunction

// Only written operands get a destination
function automatic void dest_of(input int src, input int idx, input logic is_write,
                                input word_t addr, output dest_kind_e kind, output word_t sel);
  kind = dest_none;
  sel  = '0;
  if (is_write && src == src_reg) begin
    kind = dest_reg;
    sel  = 32'd1 << idx;
  end else if (is_write && src == src_mem) begin
    kind = dest_mem;
    sel  = addr;
  end
endfunction

// Expected outputs for the request that is on the DUT inputs right now
function automatic void expected_outputs(output word_t e_op0, output word_t e_op1,
                                         output dest_kind_e e_k0, output dest_kind_e e_k1,
                                         output word_t e_s0, output word_t e_s1,
                                         output body_len_t e_len, output word_t e_addr);
  logic [7:0] modrm;
  logic [7:0] sib;
  logic [1:0] md;
  logic [2:0] base;
  int         has_modrm;
  int         has_sib;
  int         disp_len;
  int         imm_len;
  int         src0;
  int         src1;
  int         idx0;
  int         idx1;
  word_t      disp;
  word_t      imm;
  word_t      base_v;
  word_t      index_v;
  word_t      mem_v;
  modrm     = byte_at(1);
  sib       = byte_at(2);
  md        = modrm[7:6];
  has_modrm = (opnd_form inside {form_rm, form_rm_reg, form_reg_rm, form_rm_imm}) ? 1 : 0;
  has_sib   = (has_modrm != 0 && md != 2'b11 && modrm[2:0] == 3'b100) ? 1 : 0;
  // Displacement size from mod, with the two mod 00 escapes to disp32
  disp_len = 0;
  if (has_modrm != 0 && md == 2'b01)
    disp_len = 1;
  else if (has_modrm != 0 && md == 2'b10)
    disp_len = 4;
  else if (has_modrm != 0 && md == 2'b00 && has_sib == 0 && modrm[2:0] == 3'b101)
    disp_len = 4;
  else if (has_sib != 0 && md == 2'b00 && sib[2:0] == 3'b101)
    disp_len = 4;
  imm_len = 0;
  if (opnd_form inside {form_imm, form_eax_imm, form_reg_imm, form_rm_imm})
    imm_len = imm_1byte ? 1 : 4;
  disp  = field_at(1 + has_modrm + has_sib, disp_len);
  imm   = field_at(1 + has_modrm + has_sib + disp_len, imm_len);
  e_len = body_len_t'(has_modrm + has_sib + disp_len + imm_len);
  // Effective address with the no-base and no-index encodings
  base    = (has_sib != 0) ? sib[2:0] : modrm[2:0];
  base_v  = (md == 2'b00 && base == 3'b101) ? '0 : gpr[base];
  index_v = (has_sib != 0 && sib[5:3] != 3'b100) ? (gpr[sib[5:3]] << sib[7:6]) : '0;
  e_addr  = base_v + index_v + disp;
  if (opc == cmd_lea)
    mem_v = e_addr;
  else if (!hint1_is_write && hint1_address == e_addr)
    mem_v = hint1_data;
  else if (!hint2_is_write && hint2_address == e_addr)
    mem_v = hint2_data;
  else
    mem_v = '0;
  src0 = src_none;
  src1 = src_none;
  idx0 = int'(instr[2:0]);
  idx1 = int'(instr[2:0]);
  case (opnd_form)
    form_reg: src0 = src_reg;
    form_imm: src0 = src_imm;
    form_eax_imm: begin
      src0 = src_reg;
      idx0 = 0;
      src1 = src_imm;
    end
    form_reg_imm: begin
      src0 = src_reg;
      src1 = src_imm;
    end
    form_eax_reg: begin
      src0 = src_reg;
      idx0 = 0;
      src1 = src_reg;
    end
    form_rm: src0 = src_rm;
    form_rm_reg: begin
      src0 = src_rm;
      src1 = src_reg;
      idx1 = int'(modrm[5:3]);
    end
    form_reg_rm: begin
      src0 = src_reg;
      idx0 = int'(modrm[5:3]);
      src1 = src_rm;
    end
    form_rm_imm: begin
      src0 = src_rm;
      src1 = src_imm;
    end
    default: src0 = src_none;
  endcase
  // An rm operand is a register in mod 11 and memory in every other mode
  if (src0 == src_rm) begin
    idx0 = int'(modrm[2:0]);
    src0 = (md == 2'b11) ? src_reg : src_mem;
  end
  if (src1 == src_rm) begin
    idx1 = int'(modrm[2:0]);
    src1 = (md == 2'b11) ? src_reg : src_mem;
  end
  e_op0 = read_value(src0, idx0, opnd0_is_read, mem_v, imm);
  e_op1 = opnd1_is_one ? 32'd1 : read_value(src1, idx1, opnd1_is_read, mem_v, imm);
  dest_of(src0, idx0, opnd0_is_write, e_addr, e_k0, e_s0);
  dest_of(src1, idx1, opnd1_is_write, e_addr, e_k1, e_s1);
endfunction

// Random request on the DUT inputs, half of them with a hint aimed at the address
task automatic draw_request();
  word_t      d0;
  word_t      d1;
  word_t      s0;
  word_t      s1;
  word_t      addr;
  dest_kind_e k0;
  dest_kind_e k1;
  body_len_t  len;
  int         hint_case;
  opnd_form      = opnd_form_e'(4'($urandom_range(0, 9)));
  opc            = opc_e'(2'($urandom_range(0, 2)));
  imm_1byte      = 1'($urandom_range(0, 1));
  opnd0_is_read  = 1'($urandom_range(0, 1));
  opnd0_is_write = 1'($urandom_range(0, 1));
  opnd1_is_read  = 1'($urandom_range(0, 1));
  opnd1_is_write = 1'($urandom_range(0, 1));
  opnd1_is_one   = ($urandom_range(0, 3) == 0);
  for (int i = 0; i < 8; i++) begin
    gpr[i] = $urandom;
  end
  for (int i = 0; i < instr_bits / 8; i++) begin
    instr[8*i +: 8] = 8'($urandom);
  end
  // Push a third of the requests onto rm 100 so SIB shows up often
  if ($urandom_range(0, 2) == 0)
    instr[10:8] = 3'b100;
  hint1_is_write = 1'($urandom_range(0, 1));
  hint1_address  = $urandom;
  hint1_data     = $urandom;
  hint2_is_write = 1'($urandom_range(0, 1));
  hint2_address  = $urandom;
  hint2_data     = $urandom;
  expected_outputs(d0, d1, k0, k1, s0, s1, len, addr);
  hint_case = $urandom_range(0, 5);
  if (hint_case == 3 || hint_case == 5)
    hint1_address = addr;
  if (hint_case == 4 || hint_case == 5)
    hint2_address = addr;
endtask

`endif

// File: sim/decode_opnds_tb.sv
`timescale 1ns/1ps

module decode_opnds_tb import operand_pkg::*; ();

  localparam int num_trans        = 400;
  localparam int reset_cycles     = 10;
  localparam int cycles_per_trans = 6;
  // Reset, every transaction at its longest, and some slack
  localparam int max_cycles = reset_cycles + num_trans * cycles_per_trans + 590;

  logic                  clk;
  logic                  reset;
  logic                  req;
  logic [instr_bits-1:0] instr;
  reg_file_t             gpr;
  opc_e                  opc;
  opnd_form_e            opnd_form;
  logic                  imm_1byte;
  logic                  opnd0_is_read;
  logic                  opnd0_is_write;
  logic                  opnd1_is_read;
  logic                  opnd1_is_write;
  logic                  opnd1_is_one;
  logic                  hint1_is_write;
  word_t                 hint1_address;
  word_t                 hint1_data;
  logic                  hint2_is_write;
  word_t                 hint2_address;
  word_t                 hint2_data;
  logic                  ack;
  word_t                 opnd0_r;
  word_t                 opnd1_r;
  dest_kind_e            dest0_kind;
  dest_kind_e            dest1_kind;
  word_t                 dest0_sel;
  word_t                 dest1_sel;
  body_len_t             instr_body_len;
  int                    cycle_count = 0;

  `include "decode_ref.svh"

  decode_opnds decode_opnds_inst (.*);

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Runs one four-phase handshake and with hold keeps req up while the inputs change
  task automatic run_transaction(input bit hold);
    word_t      held_op0;
    word_t      held_op1;
    word_t      held_s0;
    word_t      held_s1;
    word_t      held_addr;
    dest_kind_e held_k0;
    dest_kind_e held_k1;
    body_len_t  held_len;
    draw_request();
    req = 1'b1;
    do begin
      @(posedge clk);
      #5;
    end while (!ack);
    if (hold) begin
      // The captured request is still on the inputs here
      expected_outputs(held_op0, held_op1, held_k0, held_k1, held_s0, held_s1, held_len,
                       held_addr);
      draw_request();
      repeat (2) begin
        @(posedge clk);
        #5;
      end
      // Nothing new may be captured while req stays high
      check_value("ack", 32'd1, ack);
      check_value("opnd0_r", held_op0, opnd0_r);
      check_value("opnd1_r", held_op1, opnd1_r);
      check_value("dest0_kind", held_k0, dest0_kind);
      check_value("dest1_kind", held_k1, dest1_kind);
      check_value("dest0_sel", held_s0, dest0_sel);
      check_value("dest1_sel", held_s1, dest1_sel);
      check_value("instr_body_len", held_len, instr_body_len);
    end
    req = 1'b0;
    @(posedge clk);
    #5;
    // ack drops on the first edge that samples req low
    check_value("ack", 32'd0, ack);
  endtask

  initial begin
    void'($urandom(32'h36a5_7509));
    clk            = 1'b0;
    reset          = 1'b1;
    req            = 1'b0;
    instr          = '0;
    gpr            = '0;
    opc            = cmd_alu;
    opnd_form      = form_none;
    imm_1byte      = 1'b0;
    opnd0_is_read  = 1'b0;
    opnd0_is_write = 1'b0;
    opnd1_is_read  = 1'b0;
    opnd1_is_write = 1'b0;
    opnd1_is_one   = 1'b0;
    hint1_is_write = 1'b0;
    hint1_address  = '0;
    hint1_data     = '0;
    hint2_is_write = 1'b0;
    hint2_address  = '0;
    hint2_data     = '0;
    repeat (reset_cycles) @(posedge clk);
    #5;
    reset = 1'b0;
    check_value("ack", 32'd0, ack);
    check_value("opnd0_r", 32'd0, opnd0_r);
    check_value("opnd1_r", 32'd0, opnd1_r);
    check_value("dest0_kind", dest_none, dest0_kind);
    check_value("dest1_kind", dest_none, dest1_kind);
    check_value("dest0_sel", 32'd0, dest0_sel);
    check_value("dest1_sel", 32'd0, dest1_sel);
    check_value("instr_body_len", 32'd0, instr_body_len);
    for (int t = 0; t < num_trans; t++) begin
      run_transaction(t % 8 == 3);
    end
    $display("Result: PASSED");
    $finish;
  end

  // Results settle with ack while the inputs stay held for another 4 ns
  initial begin
    word_t      e_op0;
    word_t      e_op1;
    word_t      e_s0;
    word_t      e_s1;
    word_t      e_addr;
    dest_kind_e e_k0;
    dest_kind_e e_k1;
    body_len_t  e_len;
    forever begin
      @(posedge ack);
      #1;
      expected_outputs(e_op0, e_op1, e_k0, e_k1, e_s0, e_s1, e_len, e_addr);
      check_value("opnd0_r", e_op0, opnd0_r);
      check_value("opnd1_r", e_op1, opnd1_r);
      check_value("dest0_kind", e_k0, dest0_kind);
      check_value("dest1_kind", e_k1, dest1_kind);
      check_value("dest0_sel", e_s0, dest0_sel);
      check_value("dest1_sel", e_s1, dest1_sel);
      check_value("instr_body_len", e_len, instr_body_len);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

// File: decode_opnds.f
+incdir+sim
logic/operand_pkg.sv
logic/modrm_decoder.sv
logic/memory_operand.sv
logic/operand_router.sv
logic/decode_handshake.sv
logic/decode_opnds.sv
sim/decode_opnds_tb.sv

// File: Bender.yml
package:
  name: decode_opnds

sources:
  - files:
      - logic/operand_pkg.sv
      - logic/modrm_decoder.sv
      - logic/memory_operand.sv
      - logic/operand_router.sv
      - logic/decode_handshake.sv
      - logic/decode_opnds.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/decode_opnds_tb.sv
